// ==== verilog/ctrl_endp_config.svh ====
/*
 * control endpoint configuration
 * device identity, endpoint 0 packet size and counter widths
 */
`ifndef CTRL_ENDP_CONFIG_SVH
`define CTRL_ENDP_CONFIG_SVH

// device identity reported in the device descriptor
`define CE_VENDOR_ID      16'hfff0
`define CE_PRODUCT_ID     16'h0001

`define CE_EP0_MAXPKT     8'd8   // full speed ep0 packet size

// standard device descriptor length
`define CE_DEV_DESCR_LEN  18

// data stage byte counter, also wLength after saturation
`define CE_BC_WIDTH       5

`endif

// ==== verilog/usb_std_pkg.sv ====
/*
 * usb standard definitions
 * request codes, recipients and descriptor types from chapter 9
 */
package usb_std_pkg;

   // standard bRequest codes handled by ep0
   typedef enum logic [7:0] {
      STD_SET_ADDRESS       = 8'd5,
      STD_GET_DESCRIPTOR    = 8'd6,
      STD_GET_CONFIGURATION = 8'd8,
      STD_SET_CONFIGURATION = 8'd9
   } usb_std_req_e;

   // bmRequestType[1:0]
   typedef enum logic [1:0] {
      REC_DEVICE    = 2'd0,
      REC_INTERFACE = 2'd1,
      REC_ENDPOINT  = 2'd2
   } usb_recipient_e;

   // high byte of wValue in GET_DESCRIPTOR
   typedef enum logic [7:0] {
      DESCR_DEVICE        = 8'd1,
      DESCR_CONFIGURATION = 8'd2,
      DESCR_STRING        = 8'd3
   } usb_descr_type_e;

endpackage

// ==== verilog/ctrl_endp_pkg.sv ====
/*
 * control endpoint internal types
 * transfer stage, decoded request and device state
 */
package ctrl_endp_pkg;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_SETUP,
      ST_DATA,
      ST_STATUS,
      ST_STALL    // held until next setup
   } stage_e;

   typedef enum logic [2:0] {
      REQ_NONE,
      REQ_GET_CONFIG,
      REQ_GET_DEV_DESCR,
      REQ_SET_ADDRESS,
      REQ_SET_CONFIG,
      REQ_UNSUPPORTED
   } req_e;

   typedef enum logic [1:0] {
      DEV_DEFAULT,
      DEV_ADDRESS,
      DEV_CONFIGURED
   } dev_state_e;

endpackage

// ==== verilog/setup_if.sv ====
/*
 * decoded setup packet
 * driven by the setup decoder, read by the stage FSM and device state
 */
`include "ctrl_endp_config.svh"

interface setup_if;
   import ctrl_endp_pkg::*;

   req_e                    req;
   logic                    in_dir;      // bmRequestType[7]
   logic [`CE_BC_WIDTH-1:0] max_length;  // saturated wLength
   logic [6:0]              wvalue_lo;   // address or config value
   logic                    complete;    // exactly eight bytes seen

   modport decoder (output req, in_dir, max_length, wvalue_lo, complete);
   modport fsm (input req, in_dir, max_length, complete);
   modport devstate (input req, wvalue_lo);

endinterface

// ==== verilog/setup_decoder.sv ====
/*
 * setup packet decoder
 * counts the eight setup bytes, checks every field and reduces the
 * packet to one supported request or UNSUPPORTED
 */
`include "ctrl_endp_config.svh"

module setup_decoder (
   input  logic                      clk_i,
   input  logic                      rstn_i,
   input  logic                      usb_reset_i,
   input  logic                      setup_i,
   input  logic                      out_valid_i,
   input  logic                      out_ready_i,
   input  logic [7:0]                out_data_i,
   input  ctrl_endp_pkg::dev_state_e dev_state_i,
   setup_if.decoder                  sif
);
   import ctrl_endp_pkg::*;
   import usb_std_pkg::*;

   localparam int BCW = `CE_BC_WIDTH;

   logic [3:0]     byte_cnt_q;  // 9 marks an overlong packet
   req_e           req_q, req_d;
   logic           in_dir_q, in_dir_d;
   logic [BCW-1:0] max_len_q, max_len_d;
   logic [6:0]     wvalue_q, wvalue_d;
   logic           bad;
   logic           setup_stb;
   logic           data_stb;

   assign setup_stb = out_ready_i & setup_i;
   assign data_stb  = out_ready_i & out_valid_i & ~setup_i;

   always_comb begin
      req_d     = req_q;
      in_dir_d  = in_dir_q;
      max_len_d = max_len_q;
      wvalue_d  = wvalue_q;
      bad       = 1'b0;
      case (byte_cnt_q)
         4'd0: begin // bmRequestType, standard type to device only
            in_dir_d = out_data_i[7];
            bad = (out_data_i[6:5] != 2'b00) || (out_data_i[4:2] != 3'b000) ||
                  (out_data_i[1:0] != REC_DEVICE);
         end
         4'd1: begin // bRequest
            case (out_data_i)
               STD_GET_CONFIGURATION: begin
                  req_d = REQ_GET_CONFIG;
                  bad   = ~in_dir_q || (dev_state_i == DEV_DEFAULT);
               end
               STD_GET_DESCRIPTOR: begin
                  req_d = REQ_GET_DEV_DESCR; // type checked in wValue high
                  bad   = ~in_dir_q;
               end
               STD_SET_ADDRESS: begin
                  req_d = REQ_SET_ADDRESS;
                  bad   = in_dir_q;
               end
               STD_SET_CONFIGURATION: begin
                  req_d = REQ_SET_CONFIG;
                  bad   = in_dir_q || (dev_state_i == DEV_DEFAULT);
               end
               default: bad = 1'b1;
            endcase
         end
         4'd2: begin // wValue low
            wvalue_d = out_data_i[6:0];
            case (req_q)
               REQ_SET_ADDRESS: bad = out_data_i[7];     // address above 127
               REQ_SET_CONFIG:  bad = out_data_i > 8'd1;
               default:         bad = out_data_i != 8'd0; // descriptor index too
            endcase
         end
         4'd3: begin // wValue high
            if (req_q == REQ_GET_DEV_DESCR)
               bad = out_data_i != DESCR_DEVICE;
            else
               bad = out_data_i != 8'd0;
         end
         4'd4, 4'd5: bad = out_data_i != 8'd0; // wIndex
         4'd6: begin // wLength low
            max_len_d = ((out_data_i >> BCW) != 8'd0) ? '1 : out_data_i[BCW-1:0];
            case (req_q)
               REQ_GET_CONFIG:    bad = out_data_i != 8'd1;
               REQ_GET_DEV_DESCR: bad = 1'b0;
               default:           bad = out_data_i != 8'd0;
            endcase
         end
         4'd7: begin // wLength high
            if (out_data_i != 8'd0) begin
               if (req_q == REQ_GET_DEV_DESCR)
                  max_len_d = '1;  // saturate, descriptor is short anyway
               else
                  bad = 1'b1;
            end
         end
         default: ;
      endcase
      // once rejected the request stays rejected
      if (bad || req_q == REQ_UNSUPPORTED)
         req_d = REQ_UNSUPPORTED;
   end

   always_ff @(posedge clk_i or negedge rstn_i) begin
      if (!rstn_i) begin
         byte_cnt_q <= 4'd0;
         req_q      <= REQ_NONE;
      end else if (usb_reset_i || setup_stb) begin
         byte_cnt_q <= 4'd0;
         req_q      <= REQ_NONE;
      end else if (data_stb && byte_cnt_q != 4'd9) begin
         byte_cnt_q <= byte_cnt_q + 4'd1;
         if (byte_cnt_q < 4'd8)
            req_q <= req_d;
      end
   end

   // packet fields, only meaningful once complete
   always_ff @(posedge clk_i) begin
      if (data_stb && byte_cnt_q < 4'd8) begin
         in_dir_q  <= in_dir_d;
         max_len_q <= max_len_d;
         wvalue_q  <= wvalue_d;
      end
   end

   assign sif.req        = req_q;
   assign sif.in_dir     = in_dir_q;
   assign sif.max_length = max_len_q;
   assign sif.wvalue_lo  = wvalue_q;
   assign sif.complete   = byte_cnt_q == 4'd8;

endmodule

// ==== verilog/transfer_fsm.sv ====
/*
 * control transfer stage FSM
 * sequences setup, data, status and stall stages from the SIE strobes,
 * counts data stage bytes and signals the acknowledged status stage
 */
`include "ctrl_endp_config.svh"

module transfer_fsm (
   input  logic                    clk_i,
   input  logic                    rstn_i,
   input  logic                    usb_reset_i,
   input  logic                    setup_i,
   input  logic                    out_valid_i,
   input  logic                    out_err_i,
   input  logic                    out_ready_i,
   input  logic                    in_req_i,
   input  logic                    in_ready_i,
   input  logic                    in_data_ack_i,
   setup_if.fsm                    sif,
   output logic                    stall_o,
   output logic                    in_valid_o,
   output logic                    in_zlp_o,
   output logic [`CE_BC_WIDTH-1:0] in_byte_idx_o,
   output logic                    commit_o
);
   import ctrl_endp_pkg::*;

   localparam int BCW = `CE_BC_WIDTH;

   stage_e         stage_q, stage_d;
   logic [BCW-1:0] byte_cnt_q, byte_cnt_d;
   logic [BCW-1:0] resp_len;
   logic [BCW-1:0] limit;
   logic           last;
   logic           in_req_q;
   logic           strobe;
   logic           setup_ev, err_ev, data_ev, ack_ev, end_ev;
   logic           resp_valid, resp_zlp;

   // decode the kind of OUT strobe
   assign strobe   = out_ready_i | in_ready_i;
   assign setup_ev = out_ready_i & setup_i;
   assign err_ev   = out_ready_i & out_err_i & ~setup_i;
   assign data_ev  = out_ready_i & out_valid_i & ~setup_i & ~out_err_i;
   assign ack_ev   = out_ready_i & in_data_ack_i & ~setup_i & ~out_err_i & ~out_valid_i;
   assign end_ev   = out_ready_i & ~setup_i & ~out_err_i & ~out_valid_i & ~in_data_ack_i;

   // bytes to send: smaller of wLength and the response
   assign resp_len = (sif.req == REQ_GET_DEV_DESCR) ? BCW'(`CE_DEV_DESCR_LEN) : BCW'(1);
   assign limit    = (sif.max_length < resp_len) ? sif.max_length : resp_len;
   assign last     = byte_cnt_q == limit;

   always_comb begin
      stage_d    = stage_q;
      byte_cnt_d = byte_cnt_q;
      resp_valid = 1'b0;
      resp_zlp   = 1'b0;
      commit_o   = 1'b0;
      case (stage_q)
         ST_IDLE: begin
            if (data_ev || in_ready_i)
               stage_d = ST_STALL;
         end
         ST_SETUP: begin
            if (ack_ev || in_ready_i)
               stage_d = ST_STALL;
            else if (end_ev) begin
               if (!sif.complete || sif.req == REQ_UNSUPPORTED)
                  stage_d = ST_STALL;
               else if (sif.in_dir && sif.max_length != '0)
                  stage_d = ST_DATA;
               else
                  stage_d = ST_STATUS; // OUT request or zero wLength
            end
         end
         ST_DATA: begin
            resp_valid = ~last;
            if (data_ev)
               stage_d = ST_STALL;
            else if (in_ready_i) begin
               if (last)
                  stage_d = ST_STALL; // host reads past the end
               else
                  byte_cnt_d = byte_cnt_q + 1'b1;
            end else if (ack_ev && last)
               stage_d = ST_STATUS;
         end
         ST_STATUS: begin
            if (!sif.in_dir) begin
               resp_valid = 1'b1;  // zero length handshake packet
               resp_zlp   = 1'b1;
               if (ack_ev) begin
                  commit_o = 1'b1;
                  stage_d  = ST_IDLE;
               end else if (data_ev || end_ev)
                  stage_d = ST_STALL;
            end else begin
               if (end_ev)
                  stage_d = ST_IDLE;
               else if (data_ev || in_ready_i)
                  stage_d = ST_STALL;
            end
         end
         default: ; // stall waits for setup
      endcase

      if (setup_ev) begin
         stage_d    = ST_SETUP;
         byte_cnt_d = '0;
      end else if (err_ev && stage_q != ST_STALL)
         stage_d = ST_IDLE;
   end

   always_ff @(posedge clk_i or negedge rstn_i) begin
      if (!rstn_i) begin
         stage_q    <= ST_IDLE;
         byte_cnt_q <= '0;
      end else if (usb_reset_i) begin
         stage_q    <= ST_IDLE;
         byte_cnt_q <= '0;
      end else if (strobe) begin
         stage_q    <= stage_d;
         byte_cnt_q <= byte_cnt_d;
      end
   end

   always_ff @(posedge clk_i or negedge rstn_i) begin
      if (!rstn_i)
         in_req_q <= 1'b0;
      else
         in_req_q <= in_req_i;
   end

   assign stall_o       = stage_q == ST_STALL;
   assign in_valid_o    = in_req_q & resp_valid;
   assign in_zlp_o      = in_req_q & resp_zlp;
   assign in_byte_idx_o = byte_cnt_q;

endmodule

// ==== verilog/device_state.sv ====
/*
 * device address and state
 * loads the new address or configuration when the status stage of the
 * request is acknowledged
 */
module device_state (
   input  logic                      clk_i,
   input  logic                      rstn_i,
   input  logic                      usb_reset_i,
   input  logic                      commit_i,
   setup_if.devstate                 sif,
   output ctrl_endp_pkg::dev_state_e dev_state_o,
   output logic [6:0]                addr_o,
   output logic                      configured_o
);
   import ctrl_endp_pkg::*;

   dev_state_e state_q;
   logic [6:0] addr_q;

   always_ff @(posedge clk_i or negedge rstn_i) begin
      if (!rstn_i) begin
         state_q <= DEV_DEFAULT;
         addr_q  <= 7'd0;
      end else if (usb_reset_i) begin
         state_q <= DEV_DEFAULT;
         addr_q  <= 7'd0;
      end else if (commit_i) begin
         case (sif.req)
            REQ_SET_ADDRESS: begin
               addr_q <= sif.wvalue_lo;
               // address 0 drops back to default
               state_q <= (sif.wvalue_lo == 7'd0) ? DEV_DEFAULT : DEV_ADDRESS;
            end
            REQ_SET_CONFIG: begin
               state_q <= sif.wvalue_lo[0] ? DEV_CONFIGURED : DEV_ADDRESS;
            end
            default: ;
         endcase
      end
   end

   assign dev_state_o  = state_q;
   assign addr_o       = addr_q;
   assign configured_o = state_q == DEV_CONFIGURED;

endmodule

// ==== verilog/descriptor_rom.sv ====
/*
 * IN data source
 * device descriptor table and the GET_CONFIGURATION reply byte
 */
`include "ctrl_endp_config.svh"

module descriptor_rom (
   input  ctrl_endp_pkg::req_e       req_i,
   input  logic [`CE_BC_WIDTH-1:0]   byte_idx_i,
   input  ctrl_endp_pkg::dev_state_e dev_state_i,
   output logic [7:0]                in_data_o
);
   import ctrl_endp_pkg::*;
   import usb_std_pkg::*;

   localparam logic [15:0] VID = `CE_VENDOR_ID;
   localparam logic [15:0] PID = `CE_PRODUCT_ID;

   // cdc device, class info at interface level
   localparam logic [7:0] DEV_DESCR [`CE_DEV_DESCR_LEN] = '{
      8'(`CE_DEV_DESCR_LEN), // bLength
      8'(DESCR_DEVICE),
      8'h00,                 // bcdUSB 2.00
      8'h02,
      8'h02,                 // bDeviceClass communications
      8'h00,
      8'h00,
      `CE_EP0_MAXPKT,
      VID[7:0],
      VID[15:8],
      PID[7:0],
      PID[15:8],
      8'h00,                 // bcdDevice 1.00
      8'h01,
      8'h00,                 // no strings
      8'h00,
      8'h00,
      8'h01                  // bNumConfigurations
   };

   always_comb begin
      in_data_o = 8'h00;
      case (req_i)
         REQ_GET_CONFIG: in_data_o = {7'd0, dev_state_i == DEV_CONFIGURED};
         REQ_GET_DEV_DESCR: begin
            if (byte_idx_i < `CE_DEV_DESCR_LEN)
               in_data_o = DEV_DESCR[byte_idx_i];
         end
         default: ;
      endcase
   end

endmodule

// ==== verilog/ctrl_endp.sv ====
/*
 * usb full speed control endpoint 0
 * answers GET_DESCRIPTOR, SET_ADDRESS and the configuration requests
 * behind a serial interface engine, stalls everything else
 */
`include "ctrl_endp_config.svh"

module ctrl_endp (
   input  logic       clk_i,
   input  logic       rstn_i,
   input  logic       usb_reset_i,
   input  logic       setup_i,
   input  logic [7:0] out_data_i,
   input  logic       out_valid_i,
   input  logic       out_err_i,
   input  logic       out_ready_i,
   input  logic       in_req_i,
   input  logic       in_ready_i,
   input  logic       in_data_ack_i,
   output logic       configured_o,
   output logic [6:0] addr_o,
   output logic       stall_o,
   output logic [7:0] in_data_o,
   output logic       in_zlp_o,
   output logic       in_valid_o
);
   import ctrl_endp_pkg::*;

   setup_if                 sif ();
   dev_state_e              dev_state;
   logic                    commit;       // status stage acked
   logic [`CE_BC_WIDTH-1:0] in_byte_idx;

   setup_decoder i_setup_decoder (
      .clk_i       (clk_i),
      .rstn_i      (rstn_i),
      .usb_reset_i (usb_reset_i),
      .setup_i     (setup_i),
      .out_valid_i (out_valid_i),
      .out_ready_i (out_ready_i),
      .out_data_i  (out_data_i),
      .dev_state_i (dev_state),
      .sif         (sif)
   );

   transfer_fsm i_transfer_fsm (
      .clk_i         (clk_i),
      .rstn_i        (rstn_i),
      .usb_reset_i   (usb_reset_i),
      .setup_i       (setup_i),
      .out_valid_i   (out_valid_i),
      .out_err_i     (out_err_i),
      .out_ready_i   (out_ready_i),
      .in_req_i      (in_req_i),
      .in_ready_i    (in_ready_i),
      .in_data_ack_i (in_data_ack_i),
      .sif           (sif),
      .stall_o       (stall_o),
      .in_valid_o    (in_valid_o),
      .in_zlp_o      (in_zlp_o),
      .in_byte_idx_o (in_byte_idx),
      .commit_o      (commit)
   );

   device_state i_device_state (
      .clk_i        (clk_i),
      .rstn_i       (rstn_i),
      .usb_reset_i  (usb_reset_i),
      .commit_i     (commit),
      .sif          (sif),
      .dev_state_o  (dev_state),
      .addr_o       (addr_o),
      .configured_o (configured_o)
   );

   descriptor_rom i_descriptor_rom (
      .req_i       (sif.req),
      .byte_idx_i  (in_byte_idx),
      .dev_state_i (dev_state),
      .in_data_o   (in_data_o)
   );

endmodule

// ==== test/ctrl_endp_checker.sv ====
/*
 * control endpoint checker
 * follows the SIE traffic on the DUT ports with its own model of the
 * setup decode, transfer stages, device state and device descriptor,
 * and compares the DUT outputs with that model on every clock edge
 */
`include "ctrl_endp_config.svh"

module ctrl_endp_checker (
   input logic       clk_i,
   input logic       rstn_i,
   input logic       usb_reset_i,
   input logic       setup_i,
   input logic [7:0] out_data_i,
   input logic       out_valid_i,
   input logic       out_ready_i,
   input logic       in_ready_i,
   input logic       in_data_ack_i,
   input logic       configured_i,
   input logic [6:0] addr_i,
   input logic       stall_i,
   input logic [7:0] in_data_i,
   input logic       in_zlp_i,
   input logic       in_valid_i
);
   timeunit 1ns;
   timeprecision 100ps;

   typedef enum {M_DEFAULT, M_ADDRESS, M_CONFIGURED} mstate_e;
   typedef enum {P_IDLE, P_SETUP, P_DATA, P_STATUS_IN, P_STATUS_OUT, P_STALL} phase_e;
   typedef enum {K_BAD, K_GET_DESCR, K_GET_CONFIG, K_SET_ADDR, K_SET_CONFIG} kind_e;

   mstate_e     state_m;
   phase_e      phase_m;
   kind_e       kind_m;
   logic [6:0]  addr_m;
   logic        stall_m;
   logic [63:0] pkt_m;     // byte 0 in the low bits
   int          nbytes_m;
   int          limit_m;   // IN bytes in the data stage
   int          idx_m;
   int          err_total = 0;
   int          test_errs = 0;
   int          test_cnt = 0;
   int          fail_tests = 0;
   string       test_name;

   // expected device descriptor
   function automatic logic [7:0] descr_byte(input int idx);
      logic [15:0] vid;
      logic [15:0] pid;
      vid = `CE_VENDOR_ID;
      pid = `CE_PRODUCT_ID;
      case (idx)
         0:       return 8'd18;  // bLength
         1:       return 8'd1;   // device type
         3:       return 8'h02;  // usb 2.00
         4:       return 8'h02;  // communications class
         7:       return 8'd8;
         8:       return vid[7:0];
         9:       return vid[15:8];
         10:      return pid[7:0];
         11:      return pid[15:8];
         13:      return 8'h01;  // device release 1.00
         17:      return 8'h01;  // one configuration
         default: return 8'h00;
      endcase
   endfunction

   // which request a full eight byte packet is, or K_BAD
   function automatic kind_e classify(input logic [63:0] pkt, input mstate_e st);
      logic [15:0] wval;
      logic [15:0] widx;
      logic [15:0] wlen;
      logic        dir;
      wval = pkt[31:16];
      widx = pkt[47:32];
      wlen = pkt[63:48];
      dir  = pkt[7];
      if (pkt[6:0] != 7'd0 || widx != 16'd0)
         return K_BAD;  // not standard, not device, or wIndex set
      case (pkt[15:8])
         8'd6: if (dir && wval == 16'h0100) return K_GET_DESCR;
         8'd8: if (dir && wval == 16'd0 && wlen == 16'd1 && st != M_DEFAULT)
                  return K_GET_CONFIG;
         8'd5: if (!dir && wval < 16'd128 && wlen == 16'd0) return K_SET_ADDR;
         8'd9: if (!dir && wval <= 16'd1 && wlen == 16'd0 && st != M_DEFAULT)
                  return K_SET_CONFIG;
         default: ;
      endcase
      return K_BAD;
   endfunction

   task automatic report_mismatch(input string msg);
      $display("[FAIL] %0d ns: %s", $time, msg);
      err_total++;
      test_errs++;
   endtask

   task automatic compare_outputs();
      if (stall_i !== stall_m)
         report_mismatch($sformatf("stall_o is %b, expected %b", stall_i, stall_m));
      if (addr_i !== addr_m)
         report_mismatch($sformatf("addr_o is %0d, expected %0d", addr_i, addr_m));
      if (configured_i !== (state_m == M_CONFIGURED))
         report_mismatch($sformatf("configured_o is %b in state %s", configured_i,
                                   state_m.name()));
   endtask

   // empty OUT closing the setup transaction
   task automatic end_of_setup();
      kind_e k;
      int    wlen;
      k    = classify(pkt_m, state_m);
      wlen = int'(pkt_m[63:48]);
      kind_m <= k;
      idx_m  <= 0;
      if (nbytes_m != 8 || k == K_BAD) begin
         phase_m <= P_STALL;
         stall_m <= 1'b1;
      end else if (k == K_GET_DESCR || k == K_GET_CONFIG) begin
         limit_m <= (k == K_GET_CONFIG) ? 1 : ((wlen < 18) ? wlen : 18);
         phase_m <= (wlen == 0) ? P_STATUS_IN : P_DATA;
      end else
         phase_m <= P_STATUS_OUT;
   endtask

   task automatic check_in_packet();
      logic [7:0] exp_data;
      if (phase_m == P_DATA) begin
         if (kind_m == K_GET_CONFIG)
            exp_data = {7'd0, state_m == M_CONFIGURED};
         else
            exp_data = descr_byte(idx_m);
         if (in_valid_i !== 1'b1 || in_zlp_i !== 1'b0)
            report_mismatch($sformatf("no data offered for IN byte %0d", idx_m));
         else if (in_data_i !== exp_data)
            report_mismatch($sformatf("IN byte %0d is %h, expected %h", idx_m, in_data_i,
                                      exp_data));
         idx_m <= idx_m + 1;
      end else if (phase_m == P_STATUS_OUT) begin
         if (in_valid_i !== 1'b1 || in_zlp_i !== 1'b1)
            report_mismatch("status stage offers no zero length packet");
      end
   endtask

   always @(posedge clk_i or negedge rstn_i) begin
      if (!rstn_i) begin
         state_m  <= M_DEFAULT;
         phase_m  <= P_IDLE;
         kind_m   <= K_BAD;
         addr_m   <= 7'd0;
         stall_m  <= 1'b0;
         nbytes_m <= 0;
         idx_m    <= 0;
         limit_m  <= 0;
      end else begin
         compare_outputs();  // pre-edge DUT against pre-edge model
         if (usb_reset_i) begin
            state_m <= M_DEFAULT;
            phase_m <= P_IDLE;
            addr_m  <= 7'd0;
            stall_m <= 1'b0;
         end else if (out_ready_i && setup_i) begin
            phase_m  <= P_SETUP;
            stall_m  <= 1'b0;
            nbytes_m <= 0;
         end else if (out_ready_i && out_valid_i) begin
            if (phase_m == P_SETUP) begin
               if (nbytes_m < 8)
                  pkt_m[8*nbytes_m +: 8] <= out_data_i;
               nbytes_m <= nbytes_m + 1;
            end
         end else if (out_ready_i && in_data_ack_i) begin
            if (phase_m == P_DATA && idx_m == limit_m)
               phase_m <= P_STATUS_IN;
            else if (phase_m == P_STATUS_OUT) begin
               // request takes effect with the status ACK
               if (kind_m == K_SET_ADDR) begin
                  addr_m  <= pkt_m[22:16];
                  state_m <= (pkt_m[22:16] == 7'd0) ? M_DEFAULT : M_ADDRESS;
               end else if (kind_m == K_SET_CONFIG)
                  state_m <= pkt_m[16] ? M_CONFIGURED : M_ADDRESS;
               phase_m <= P_IDLE;
            end
         end else if (out_ready_i) begin
            if (phase_m == P_SETUP)
               end_of_setup();
            else if (phase_m == P_STATUS_IN)
               phase_m <= P_IDLE;
         end else if (in_ready_i)
            check_in_packet();
      end
   end

   task automatic start_test(input string name);
      test_name = name;
      test_errs = 0;
   endtask

   task automatic end_test();
      test_cnt++;
      if (test_errs == 0)
         $display("test %0d %s: ok", test_cnt, test_name);
      else begin
         fail_tests++;
         $display("test %0d %s: %0d mismatches", test_cnt, test_name, test_errs);
      end
   endtask

   task automatic print_summary();
      $display("summary: %0d tests, %0d failed, %0d mismatches", test_cnt, fail_tests,
               err_total);
   endtask

endmodule

// ==== test/tb_ctrl_endp.sv ====
/*
 * control endpoint testbench
 * emulates the SIE with random control transfers, one strobe per byte,
 * and leaves the comparing to the checker
 */
module tb_ctrl_endp;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int          ROUNDS    = 20;
   localparam int          NUM_TESTS = ROUNDS * 5;  // five tests per round
   localparam logic [31:0] SEED      = 32'h1a8c804d;

   logic       clk_i;
   logic       rstn_i;
   logic       usb_reset_i;
   logic       setup_i;
   logic [7:0] out_data_i;
   logic       out_valid_i;
   logic       out_err_i;
   logic       out_ready_i;
   logic       in_req_i;
   logic       in_ready_i;
   logic       in_data_ack_i;
   logic       configured_o;
   logic [6:0] addr_o;
   logic       stall_o;
   logic [7:0] in_data_o;
   logic       in_zlp_o;
   logic       in_valid_o;

   ctrl_endp i_ctrl_endp (.*);

   ctrl_endp_checker i_checker (
      .clk_i         (clk_i),
      .rstn_i        (rstn_i),
      .usb_reset_i   (usb_reset_i),
      .setup_i       (setup_i),
      .out_data_i    (out_data_i),
      .out_valid_i   (out_valid_i),
      .out_ready_i   (out_ready_i),
      .in_ready_i    (in_ready_i),
      .in_data_ack_i (in_data_ack_i),
      .configured_i  (configured_o),
      .addr_i        (addr_o),
      .stall_i       (stall_o),
      .in_data_i     (in_data_o),
      .in_zlp_i      (in_zlp_o),
      .in_valid_i    (in_valid_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #4 clk_i = ~clk_i;
   end

   function automatic logic [63:0] make_pkt(input logic [7:0] bm_req, input logic [7:0] b_req,
                                            input logic [15:0] w_value,
                                            input logic [15:0] w_length);
      return {w_length, 16'h0000, w_value, b_req, bm_req};  // wIndex always 0
   endfunction

   task automatic idle_gap();  // 1 to 4 idle cycles
      repeat (1 + $urandom % 4) @(posedge clk_i);
   endtask

   task automatic out_strobe(input logic setup, input logic valid, input logic ack,
                             input logic [7:0] data);
      @(posedge clk_i);
      out_ready_i   <= 1'b1;
      setup_i       <= setup;
      out_valid_i   <= valid;
      in_data_ack_i <= ack;
      out_data_i    <= data;
      @(posedge clk_i);
      out_ready_i   <= 1'b0;
      setup_i       <= 1'b0;
      out_valid_i   <= 1'b0;
      in_data_ack_i <= 1'b0;
      idle_gap();
   endtask

   // IN token, the packet is taken one cycle after the request
   task automatic in_token();
      @(posedge clk_i);
      in_req_i <= 1'b1;
      @(posedge clk_i);
      in_ready_i <= 1'b1;
      @(posedge clk_i);
      in_ready_i <= 1'b0;
      in_req_i   <= 1'b0;
      idle_gap();
   endtask

   task automatic send_setup(input logic [63:0] pkt, input int nbytes);
      int i;
      out_strobe(1'b1, 1'b0, 1'b0, 8'h00);
      for (i = 0; i < nbytes; i++)
         out_strobe(1'b0, 1'b1, 1'b0, pkt[8*i +: 8]);
      out_strobe(1'b0, 1'b0, 1'b0, 8'h00);  // end of transaction
   endtask

   task automatic in_request(input logic [63:0] pkt, input int nbytes);
      send_setup(pkt, 8);
      repeat (nbytes) begin
         in_token();
         out_strobe(1'b0, 1'b0, 1'b1, 8'h00);
      end
      out_strobe(1'b0, 1'b0, 1'b0, 8'h00);  // empty OUT status
   endtask

   task automatic out_request(input logic [63:0] pkt);
      send_setup(pkt, 8);
      in_token();
      out_strobe(1'b0, 1'b0, 1'b1, 8'h00);
   endtask

   task automatic open_test(input string name);
      @(negedge clk_i);
      i_checker.start_test(name);
   endtask

   task automatic close_test();
      repeat (3) @(posedge clk_i);
      @(negedge clk_i);
      i_checker.end_test();
   endtask

   task automatic run_get_descr();
      int wlen;
      wlen = $urandom % 41;
      open_test("get_descriptor");
      in_request(make_pkt(8'h80, 8'd6, 16'h0100, 16'(wlen)), (wlen < 18) ? wlen : 18);
      close_test();
   endtask

   task automatic run_set_address();
      int addr;
      addr = 1 + $urandom % 127;
      open_test("set_address");
      out_request(make_pkt(8'h00, 8'd5, 16'(addr), 16'd0));
      close_test();
   endtask

   task automatic run_set_config();
      int cfg;
      cfg = $urandom % 2;
      open_test("set_and_get_configuration");
      out_request(make_pkt(8'h00, 8'd9, 16'(cfg), 16'd0));
      in_request(make_pkt(8'h80, 8'd8, 16'd0, 16'd1), 1);
      close_test();
   endtask

   // runs while the device is still in default
   task automatic run_bad_request();
      int         variant;
      logic [7:0] breq;
      variant = $urandom % 3;
      open_test("unsupported_request");
      case (variant)
         0: begin
            breq = 8'($urandom);
            while (breq inside {8'd5, 8'd6, 8'd8, 8'd9})
               breq = 8'($urandom);
            send_setup(make_pkt(8'h80, breq, 16'd0, 16'd0), 8);
         end
         1:       send_setup(make_pkt(8'h80, 8'd5, 16'd1, 16'd0), 8);  // SET_ADDRESS as IN
         default: send_setup(make_pkt(8'h00, 8'd9, 16'd1, 16'd0), 8);
      endcase
      repeat (8 + $urandom % 8) @(posedge clk_i);  // stall has to hold
      close_test();
   endtask

   task automatic run_short_setup();
      int nbytes;
      nbytes = $urandom % 8;
      open_test("short_setup_and_bus_reset");
      send_setup(make_pkt(8'h80, 8'd6, 16'h0100, 16'd18), nbytes);
      repeat (4) @(posedge clk_i);
      @(posedge clk_i);
      usb_reset_i <= 1'b1;
      out_ready_i <= 1'b1;
      @(posedge clk_i);
      usb_reset_i <= 1'b0;
      out_ready_i <= 1'b0;
      idle_gap();
      close_test();
   endtask

   initial begin
      int round;
      void'($urandom(SEED));
      rstn_i        <= 1'b0;
      usb_reset_i   <= 1'b0;
      setup_i       <= 1'b0;
      out_data_i    <= 8'h00;
      out_valid_i   <= 1'b0;
      out_err_i     <= 1'b0;
      out_ready_i   <= 1'b0;
      in_req_i      <= 1'b0;
      in_ready_i    <= 1'b0;
      in_data_ack_i <= 1'b0;
      repeat (16) @(posedge clk_i);
      rstn_i <= 1'b1;
      repeat (4) @(posedge clk_i);
      for (round = 0; round < ROUNDS; round++) begin
         run_get_descr();
         run_bad_request();
         run_set_address();
         run_set_config();
         run_short_setup();  // back to default for the next round
      end
      @(negedge clk_i);
      i_checker.print_summary();
      if (i_checker.err_total == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

   // watchdog
   initial begin
      repeat (NUM_TESTS * 2000) @(posedge clk_i);
      $display("timeout: the tests did not finish within %0d clock cycles", NUM_TESTS * 2000);
      $display("ERRORS FOUND");
      $finish;
   end

endmodule

// ==== tb.f ====
+incdir+verilog
verilog/usb_std_pkg.sv
verilog/ctrl_endp_pkg.sv
verilog/setup_if.sv
verilog/setup_decoder.sv
verilog/transfer_fsm.sv
verilog/device_state.sv
verilog/descriptor_rom.sv
verilog/ctrl_endp.sv
test/ctrl_endp_checker.sv
test/tb_ctrl_endp.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0 -Wno-fatal
TOP       := tb_ctrl_endp
FILELIST  := tb.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))
HEADERS   := $(wildcard verilog/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "NO ERRORS" $(LOG) || { echo "simulation did not complete"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
